// ==== rpPkg.sv ====
// Shared register map, function codes, limits and bus types for the RP disk drive model
`default_nettype none

package rpPkg;

   ////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////

   localparam int regAdrWidth = 4;

   localparam logic [regAdrWidth-1:0] regCs1 = 4'd0;
   localparam logic [regAdrWidth-1:0] regDs  = 4'd1;
   localparam logic [regAdrWidth-1:0] regEr1 = 4'd2;
   localparam logic [regAdrWidth-1:0] regDa  = 4'd5;
   localparam logic [regAdrWidth-1:0] regDc  = 4'd10;
   localparam logic [regAdrWidth-1:0] regCc  = 4'd11;

   // Function field of CS1, GO bit excluded
   localparam logic [4:0] funNop    = 5'd0;
   localparam logic [4:0] funSeek   = 5'd2;
   localparam logic [4:0] funRecal  = 5'd3;
   localparam logic [4:0] funDrvClr = 5'd4;

   ////////////////////////////////////////////////////////////
   // Mechanism limits
   ////////////////////////////////////////////////////////////

   localparam int cylWidth = 10;
   localparam logic [cylWidth-1:0] lastCyl = 10'd814;
   // Clocks spent on each one-cylinder move
   localparam int stepCycles = 4;

   // DS bits
   localparam int dsAtaBit = 15;
   localparam int dsErrBit = 14;
   localparam int dsMolBit = 12;
   localparam int dsDprBit = 8;
   localparam int dsDryBit = 7;

   // ER1 bits
   localparam int er1IlfBit = 0;
   localparam int er1RmrBit = 2;
   localparam int er1IaeBit = 10;

   ////////////////////////////////////////////////////////////
   // Bus and status types
   ////////////////////////////////////////////////////////////

   // CS1 layout, DVA at bit 11
   typedef struct packed {
      logic [3:0] rsvdHi;
      logic       dva;
      logic [4:0] rsvdLo;
      logic [4:0] fun;
      logic       go;
   } rpCs1Fields_t;

   typedef struct packed {
      logic [7:0] track;
      logic [7:0] sector;
   } rpDaFields_t;

   // One bus word, seen as CS1 or as DA
   typedef union packed {
      logic [15:0]  raw;
      rpCs1Fields_t cs1;
      rpDaFields_t  da;
   } rpWord_u;

   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [regAdrWidth-1:0] num;
      rpWord_u                data;
   } rpRegReq_t;

   typedef struct packed {
      logic       go;
      logic [4:0] fun;
   } rpCmd_t;

   // Seeker state and single-clock event pulses
   typedef struct packed {
      logic                busy;
      logic [cylWidth-1:0] curCyl;
      logic                setAta;
      logic                setIlf;
      logic                setIae;
      logic                drvClr;
   } rpSeekStat_t;

endpackage

`default_nettype wire

// ==== rpCs1.sv ====
// Control/status register 1 of the drive; holds the function code and GO for the seeker
`default_nettype none
`timescale 1ns/1ns

module rpCs1 (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire rpPkg::rpRegReq_t  req,
   input  wire logic              busy,
   input  wire logic              clrGo,
   output logic [15:0]            cs1,
   output rpPkg::rpCmd_t          cmd
);
   import rpPkg::*;

   logic [4:0] fun;
   logic       go;
   logic       cs1Wr;
   rpWord_u    word;

   // Busy drive refuses the write, RMR is logged in rpRegs
   assign cs1Wr = req.wr && (req.num == regCs1) && !busy;

   // Function code
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         fun <= '0;
      else if (cs1Wr)
         fun <= req.data.cs1.fun;
   end

   // GO, cleared by the seeker ahead of any new write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         go <= 1'b0;
      else if (clrGo)
         go <= 1'b0;
      else if (cs1Wr)
         go <= req.data.cs1.go;
   end

   // Readback word, DVA always set
   always_comb
   begin
      word.raw     = '0;
      word.cs1.dva = 1'b1;
      word.cs1.fun = fun;
      word.cs1.go  = go;
   end

   assign cs1     = word.raw;
   assign cmd.go  = go;
   assign cmd.fun = fun;

endmodule

`default_nettype wire

// ==== rpRegs.sv ====
// Drive register block with DA, DC, ER1, attention and the read multiplexer for the bus
`default_nettype none
`timescale 1ns/1ns

module rpRegs (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire rpPkg::rpRegReq_t            req,
   input  wire logic [15:0]                 cs1,
   input  wire rpPkg::rpSeekStat_t          stat,
   output logic [15:0]                      rdData,
   output logic [rpPkg::cylWidth-1:0]       desiredCyl
);
   import rpPkg::*;

   logic [7:0]          daTrack;
   logic [7:0]          daSector;
   logic [cylWidth-1:0] dcCyl;
   logic [15:0]         er1;
   logic                ata;
   logic [15:0]         ds;
   logic                protWr;
   logic                rmrHit;
   logic                daWr;
   logic                dcWr;
   logic                ataClr;

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   // CS1, DA and DC are locked while the drive is busy
   assign protWr = req.wr && (req.num == regCs1 || req.num == regDa || req.num == regDc);
   assign rmrHit = protWr && stat.busy;
   assign daWr   = req.wr && (req.num == regDa) && !stat.busy;
   assign dcWr   = req.wr && (req.num == regDc) && !stat.busy;
   // Attention drops on drive clear or a DS write with bit 15 set
   assign ataClr = stat.drvClr || (req.wr && (req.num == regDs) && req.data.raw[dsAtaBit]);

   // Desired address, track and sector
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         daTrack  <= '0;
         daSector <= '0;
      end
      else if (daWr)
      begin
         daTrack  <= req.data.da.track;
         daSector <= req.data.da.sector;
      end
   end

   // Desired cylinder
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dcCyl <= '0;
      else if (dcWr)
         dcCyl <= req.data.raw[cylWidth-1:0];
   end

   // Error register, drive clear first then new events
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else
      begin
         if (stat.drvClr)
            er1 <= '0;
         if (stat.setIlf)
            er1[er1IlfBit] <= 1'b1;
         if (stat.setIae)
            er1[er1IaeBit] <= 1'b1;
         if (rmrHit)
            er1[er1RmrBit] <= 1'b1;
      end
   end

   // Attention, a new event beats a clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (stat.setAta)
         ata <= 1'b1;
      else if (ataClr)
         ata <= 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // Status and read path
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      ds           = '0;
      ds[dsAtaBit] = ata;
      ds[dsErrBit] = |er1;
      ds[dsMolBit] = 1'b1;
      ds[dsDprBit] = 1'b1;
      ds[dsDryBit] = !stat.busy;
   end

   // Unmapped numbers read as zero
   always_comb
   begin
      case (req.num)
         regCs1:  rdData = cs1;
         regDs:   rdData = ds;
         regEr1:  rdData = er1;
         regDa:   rdData = {daTrack, daSector};
         regDc:   rdData = {{(16 - cylWidth){1'b0}}, dcCyl};
         regCc:   rdData = {{(16 - cylWidth){1'b0}}, stat.curCyl};
         default: rdData = '0;
      endcase
   end

   assign desiredCyl = dcCyl;

endmodule

`default_nettype wire

// ==== rpSeeker.sv ====
// Function executor of the drive; moves the heads and reports completion back to CS1 and ER1
`default_nettype none
`timescale 1ns/1ns

module rpSeeker (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire rpPkg::rpCmd_t               cmd,
   input  wire logic [rpPkg::cylWidth-1:0]  desiredCyl,
   output rpPkg::rpSeekStat_t               stat,
   output logic                             clrGo
);
   import rpPkg::*;

   typedef enum logic [1:0] {sIdle, sStep, sFinish} state_t;
   typedef logic [$clog2(stepCycles)-1:0] stepCnt_t;

   state_t              state;
   logic [cylWidth-1:0] curCyl;
   logic [cylWidth-1:0] targetCyl;
   stepCnt_t            stepCnt;
   // Events held until the finish state
   logic                endAta;
   logic                endIlf;
   logic                endIae;
   logic                endClr;
   logic                done;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state     <= sIdle;
         curCyl    <= '0;
         targetCyl <= '0;
         stepCnt   <= '0;
         endAta    <= 1'b0;
         endIlf    <= 1'b0;
         endIae    <= 1'b0;
         endClr    <= 1'b0;
      end
      else
      begin
         case (state)
            sIdle:
               if (cmd.go)
               begin
                  endAta  <= 1'b0;
                  endIlf  <= 1'b0;
                  endIae  <= 1'b0;
                  endClr  <= 1'b0;
                  stepCnt <= stepCnt_t'(stepCycles - 1);
                  state   <= sFinish;
                  case (cmd.fun)
                     funNop:
                        state <= sFinish;
                     funDrvClr:
                        endClr <= 1'b1;
                     funSeek:
                     begin
                        endAta <= 1'b1;
                        // Out of range, heads stay put
                        if (desiredCyl > lastCyl)
                           endIae <= 1'b1;
                        else
                        begin
                           targetCyl <= desiredCyl;
                           state     <= sStep;
                        end
                     end
                     funRecal:
                     begin
                        endAta    <= 1'b1;
                        targetCyl <= '0;
                        state     <= sStep;
                     end
                     default:
                     begin
                        endAta <= 1'b1;
                        endIlf <= 1'b1;
                     end
                  endcase
               end
            // One cylinder per stepCycles clocks
            sStep:
               if (curCyl == targetCyl)
                  state <= sFinish;
               else if (stepCnt == '0)
               begin
                  stepCnt <= stepCnt_t'(stepCycles - 1);
                  if (curCyl < targetCyl)
                     curCyl <= curCyl + 1'b1;
                  else
                     curCyl <= curCyl - 1'b1;
               end
               else
                  stepCnt <= stepCnt - 1'b1;
            sFinish:
               state <= sIdle;
            default:
               state <= sIdle;
         endcase
      end
   end

   assign done  = (state == sFinish);
   assign clrGo = done;

   // GO counts as busy before the first step so DRY drops at once
   assign stat.busy   = cmd.go || (state != sIdle);
   assign stat.curCyl = curCyl;
   assign stat.setAta = done && endAta;
   assign stat.setIlf = done && endIlf;
   assign stat.setIae = done && endIae;
   assign stat.drvClr = done && endClr;

endmodule

`default_nettype wire

// ==== rpWbSlave.sv ====
// Wishbone classic slave port; turns bus cycles into single-clock register strobes
`default_nettype none
`timescale 1ns/1ns

module rpWbSlave (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire logic                           cyc,
   input  wire logic                           stb,
   input  wire logic                           we,
   input  wire logic [rpPkg::regAdrWidth-1:0]  adr,
   input  wire logic [15:0]                    datIn,
   output logic [15:0]                         datOut,
   output logic                                ack,
   output rpPkg::rpRegReq_t                    req,
   input  wire logic [15:0]                    rdData
);
   import rpPkg::*;

   logic newCyc;

   // First sample of a strobe not yet answered
   assign newCyc = cyc && stb && !ack;

   // One wait state, then a single ack clock
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= newCyc;
   end

   // Read word captured at the edge that raises ack
   always_ff @(posedge clk)
   begin
      if (newCyc)
         datOut <= rdData;
   end

   // Address and data are held by the master through the ack clock
   always_comb
   begin
      req.wr       = ack && we;
      req.rd       = ack && !we;
      req.num      = adr;
      req.data.raw = datIn;
   end

endmodule

`default_nettype wire

// ==== rpDrive.sv ====
// Top level of the RP drive model; joins the Wishbone port, registers and seek mechanism
`default_nettype none
`timescale 1ns/1ns

module rpDrive (
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire logic                           cyc,
   input  wire logic                           stb,
   input  wire logic                           we,
   input  wire logic [rpPkg::regAdrWidth-1:0]  adr,
   input  wire logic [15:0]                    datIn,
   output logic [15:0]                         datOut,
   output logic                                ack
);
   import rpPkg::*;

   rpRegReq_t           req;
   rpCmd_t              cmd;
   rpSeekStat_t         stat;
   logic [15:0]         cs1;
   logic [15:0]         rdData;
   logic [cylWidth-1:0] desiredCyl;
   logic                clrGo;

   ////////////////////////////////////////////////////////////
   // Bus port
   ////////////////////////////////////////////////////////////

   rpWbSlave uWbSlave (
      .clk    (clk),
      .rst    (rst),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .datIn  (datIn),
      .datOut (datOut),
      .ack    (ack),
      .req    (req),
      .rdData (rdData)
   );

   // Registers
   rpCs1 uCs1 (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .busy  (stat.busy),
      .clrGo (clrGo),
      .cs1   (cs1),
      .cmd   (cmd)
   );

   rpRegs uRegs (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .cs1        (cs1),
      .stat       (stat),
      .rdData     (rdData),
      .desiredCyl (desiredCyl)
   );

   // Seek mechanism steered by CS1 and DC
   rpSeeker uSeeker (
      .clk        (clk),
      .rst        (rst),
      .cmd        (cmd),
      .desiredCyl (desiredCyl),
      .stat       (stat),
      .clrGo      (clrGo)
   );

endmodule

`default_nettype wire

// ==== rpDrive_checker.sv ====
// Bound assertion module for the RP drive; watches the Wishbone handshake and register invariants
`default_nettype none
`timescale 1ns/1ns

module rpDrive_checker (
   input wire logic                       clk,
   input wire logic                       rst,
   input wire logic                       cyc,
   input wire logic                       stb,
   input wire logic                       ack,
   input wire logic                       go,
   input wire logic [15:0]                ds,
   input wire logic [rpPkg::cylWidth-1:0] curCyl
);
   import rpPkg::*;

   ////////////////////////////////////////////////////////////
   // Bus protocol
   ////////////////////////////////////////////////////////////

   // Single-clock acknowledge
   ackOneCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else $error("ack held high for more than one cycle");

   // Ack answers a strobe seen one clock earlier
   ackAfterStb: assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
      else $error("ack raised without a preceding strobe");

   // Register invariants

   // GO held through the whole function, DRY back as GO clears
   dryWithGoClear: assert property (@(posedge clk) disable iff (rst) $fell(go) |-> ds[dsDryBit])
      else $error("GO cleared while the drive was still not ready");

   cylInRange: assert property (@(posedge clk) disable iff (rst) curCyl <= lastCyl)
      else $error("current cylinder beyond last cylinder");

endmodule

bind rpDrive rpDrive_checker chk (
   .clk    (clk),
   .rst    (rst),
   .cyc    (cyc),
   .stb    (stb),
   .ack    (ack),
   .go     (cmd.go),
   .ds     (uRegs.ds),
   .curCyl (stat.curCyl)
);

`default_nettype wire

// ==== tbRpDrive.sv ====
// Testbench for the RP drive model; replays the trace file over Wishbone and checks the reads
`default_nettype none
`timescale 1ns/1ns

module tbRpDrive;
   import rpPkg::*;

   localparam int clkPeriod   = 10;
   localparam int ackLimit    = 16;
   localparam int seekCycles  = int'(lastCyl) * stepCycles;
   // A status read takes about three clocks
   localparam int pollLimit   = seekCycles / 2 + 16;
   localparam int cyclesPerOp = 16;

   logic                   clk;
   logic                   rst;
   logic                   cyc;
   logic                   stb;
   logic                   we;
   logic [regAdrWidth-1:0] adr;
   logic [15:0]            datIn;
   logic [15:0]            datOut;
   logic                   ack;

   // Parsed trace, one entry per operation
   byte                    opQ[$];
   logic [regAdrWidth-1:0] regQ[$];
   logic [15:0]            dataQ[$];
   logic [15:0]            maskQ[$];

   int errCount    = 0;
   int checkCount  = 0;
   int pollCount   = 0;
   bit traceReady  = 1'b0;

   rpDrive dut (
      .clk    (clk),
      .rst    (rst),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .datIn  (datIn),
      .datOut (datOut),
      .ack    (ack)
   );

   always #(clkPeriod / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic string regName(input logic [regAdrWidth-1:0] num);
      case (num)
         regCs1:  return "CS1";
         regDs:   return "DS";
         regEr1:  return "ER1";
         regDa:   return "DA";
         regDc:   return "DC";
         regCc:   return "CC";
         default: return $sformatf("REG%0h", num);
      endcase
   endfunction

   // Reads the trace file, skipping comment and blank lines
   task automatic loadTrace();
      int    fd;
      int    n;
      string line;
      byte   op;
      logic [15:0] num;
      logic [15:0] data;
      logic [15:0] mask;
      fd = $fopen("rpDriveTrace.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open trace file rpDriveTrace.txt");
         errCount++;
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 1 && line[0] != "#")
            begin
               n = $sscanf(line, "%c %h %h %h", op, num, data, mask);
               if (n != 4)
               begin
                  $display("Trace line could not be parsed: %s", line);
                  errCount++;
               end
               else
               begin
                  opQ.push_back(op);
                  regQ.push_back(num[regAdrWidth-1:0]);
                  dataQ.push_back(data);
                  maskQ.push_back(mask);
                  if (op == "P")
                     pollCount++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // One classic cycle, held until ack
   task automatic busCycle(input logic wr, input logic [regAdrWidth-1:0] num,
                           input logic [15:0] wdata, output logic [15:0] rdata,
                           output bit ok);
      int waitCnt;
      waitCnt = 0;
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= wr;
      adr   <= num;
      datIn <= wdata;
      @(posedge clk);
      while (!ack && waitCnt < ackLimit)
      begin
         @(posedge clk);
         waitCnt++;
      end
      ok    = ack;
      rdata = datOut;
      cyc   <= 1'b0;
      stb   <= 1'b0;
      we    <= 1'b0;
      if (!ok)
      begin
         $display("No bus acknowledge for register %s", regName(num));
         errCount++;
      end
   endtask

   task automatic writeReg(input logic [regAdrWidth-1:0] num, input logic [15:0] wdata);
      logic [15:0] unused;
      bit          ok;
      busCycle(1'b1, num, wdata, unused, ok);
   endtask

   // Masked compare of one register read
   task automatic readCheck(input logic [regAdrWidth-1:0] num, input logic [15:0] expVal,
                            input logic [15:0] mask);
      logic [15:0] got;
      bit          ok;
      busCycle(1'b0, num, 16'h0000, got, ok);
      checkCount++;
      if (ok && ((got & mask) != (expVal & mask)))
      begin
         $display("Mismatch %s: read %h expected %h mask %h", regName(num), got & mask,
                  expVal & mask, mask);
         errCount++;
      end
   endtask

   // Repeats a read until the masked value matches, normally DRY in DS
   task automatic pollReady(input logic [regAdrWidth-1:0] num, input logic [15:0] expVal,
                            input logic [15:0] mask);
      logic [15:0] got;
      bit          ok;
      bit          done;
      int          tries;
      done  = 1'b0;
      tries = 0;
      while (!done && tries < pollLimit)
      begin
         busCycle(1'b0, num, 16'h0000, got, ok);
         tries++;
         if (!ok)
            tries = pollLimit;
         else if ((got & mask) == (expVal & mask))
            done = 1'b1;
      end
      checkCount++;
      if (!done)
      begin
         $display("Drive never became ready after %0d status reads", tries);
         errCount++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk   = 1'b0;
      rst   = 1'b1;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      datIn = '0;
      loadTrace();
      traceReady = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < opQ.size(); i++)
      begin
         case (opQ[i])
            "W": writeReg(regQ[i], dataQ[i]);
            "R": readCheck(regQ[i], dataQ[i], maskQ[i]);
            "P": pollReady(regQ[i], dataQ[i], maskQ[i]);
            default:
            begin
               $display("Unknown trace operation at entry %0d", i);
               errCount++;
            end
         endcase
      end
      $display("Checks run: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0 && checkCount > 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // Watchdog sized from the trace and the longest possible seek per poll
   initial
   begin
      longint limitCycles;
      wait (traceReady);
      limitCycles = opQ.size() * cyclesPerOp + pollCount * 2 * seekCycles + 100;
      repeat (limitCycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles and the run did not finish", limitCycles);
      $display("Checks run: %0d, errors: %0d", checkCount, errCount + 1);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rpDriveTrace.txt ====
# op reg data mask, all hex; W writes data, R reads and compares under mask
# P repeats reads of reg until (value & mask) == data
R 1 1180 ffff
R 0 0800 ffff
R 2 0000 ffff
R 5 0000 ffff
R a 0000 ffff
R b 0000 ffff
W 5 1234 0000
R 5 1234 ffff
W a 012c 0000
R a 012c ffff
R 3 0000 ffff
W 0 0005 0000
P 1 0080 0080
R 1 9180 ffff
R b 012c ffff
R 0 0804 ffff
W 0 0007 0000
P 1 0080 0080
R b 0000 ffff
R 0 0806 ffff
W 1 8000 0000
R 1 1180 ffff
W a 0384 0000
W 0 0005 0000
P 1 0080 0080
R 2 0400 ffff
R b 0000 ffff
R 1 d180 ffff
W 0 0009 0000
P 1 0080 0080
R 2 0000 ffff
R 1 1180 ffff
W 0 000b 0000
P 1 0080 0080
R 2 0001 ffff
R 1 d180 ffff
W 0 0009 0000
P 1 0080 0080
R 1 1180 ffff
W a 0320 0000
W 0 0005 0000
W a 0064 0000
R a 0320 ffff
R 1 5100 ffff
P 1 0080 0080
R 1 d180 ffff
R b 0320 ffff
R 2 0004 ffff
W 1 8000 0000
R 1 5180 ffff
W 0 0009 0000
P 1 0080 0080
R 2 0000 ffff
R 1 1180 ffff
W 0 0007 0000
P 1 0080 0080
R b 0000 ffff

// ==== build.f ====
rpPkg.sv
rpCs1.sv
rpRegs.sv
rpSeeker.sv
rpWbSlave.sv
rpDrive.sv
rpDrive_checker.sv
tbRpDrive.sv
